/* mm_accel_settings.svh */
/*
 * Sizing of the 4x4 matrix accelerator.
 * Only a 4x4 array with 32-bit elements is supported. Each buffer row holds
 * one full matrix row or column, so MM_BUF_DW must equal MM_SA * MM_DW.
 */
`ifndef MM_ACCEL_SETTINGS_SVH
`define MM_ACCEL_SETTINGS_SVH

// element width in bits
`define MM_DW 32

// array side, in elements
`define MM_SA 4

// buffer address width, one row per array line
`define MM_BUF_AW 2

// one buffer row carries MM_SA elements
`define MM_BUF_DW 128

`endif

/* mm_accel_pkg.sv */
/*
 * Shared types of the matrix accelerator.
 * The buffer row is written by the DMA as flat bits and read by the engine
 * as elements. Element 0 sits in the low bits and is the first beat received.
 */
`include "mm_accel_settings.svh"

package mm_accel_pkg;

    typedef logic signed [`MM_DW-1:0] elem_t;

    // one buffer row, seen two ways
    typedef union packed {
        logic [`MM_BUF_DW-1:0]  raw;
        elem_t [`MM_SA-1:0]     elem;
    } buf_row_u;

    // wide enough for a full dot product of signed elements
    typedef logic signed [2*`MM_DW:0] accum_t;

endpackage

/* tile_buffer.sv */
/*
 * Four-row buffer with byte-masked writes and a registered read port.
 * Read data appears one cycle after the address. Contents are undefined
 * until written, and writes are blocked while in reset.
 */
`timescale 1ns/10ps
`include "mm_accel_settings.svh"

module tile_buffer (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        wren_i,
    input  logic [`MM_BUF_AW-1:0]       waddr_i,
    input  logic [`MM_BUF_DW/8-1:0]     wbyteen_i,
    input  mm_accel_pkg::buf_row_u      wdata_i,
    input  logic [`MM_BUF_AW-1:0]       raddr_i,
    output mm_accel_pkg::buf_row_u      rdata_o
);

    logic [`MM_BUF_DW-1:0] mem [2**`MM_BUF_AW];

    always_ff @(posedge clk) begin
        if (rst_n && wren_i) begin
            for (int b = 0; b < `MM_BUF_DW/8; b++) begin
                if (wbyteen_i[b])
                    mem[waddr_i][b*8 +: 8] <= wdata_i.raw[b*8 +: 8];
            end
        end
        rdata_o <= mem[raddr_i];
    end

endmodule

/* mm_engine.sv */
/*
 * 4x4 multiply-accumulate as four outer products, one per buffer row.
 * Buffer A must hold columns of A and buffer B rows of B. done_o pulses
 * 6 cycles after start_i; accum_o then holds C until the next start.
 */
`timescale 1ns/10ps
`include "mm_accel_settings.svh"

module mm_engine (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start_i,
    output logic                        done_o,
    output logic [`MM_BUF_AW-1:0]       buf_a_raddr_o,
    input  mm_accel_pkg::buf_row_u      buf_a_rdata_i,
    output logic [`MM_BUF_AW-1:0]       buf_b_raddr_o,
    input  mm_accel_pkg::buf_row_u      buf_b_rdata_i,
    output mm_accel_pkg::accum_t        accum_o [`MM_SA][`MM_SA]
);

    logic                   issue_act;
    logic [`MM_BUF_AW-1:0]  issue_addr;
    logic                   rd_vld;
    logic                   rd_last;

    // one row address per cycle, rows 0..3 after start
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            issue_act  <= 1'b0;
            issue_addr <= '0;
        end else if (start_i) begin
            issue_act  <= 1'b1;
            issue_addr <= '0;
        end else if (issue_act) begin
            issue_addr <= issue_addr + 1'b1;
            // last row issued
            if (issue_addr == '1)
                issue_act <= 1'b0;
        end
    end

    assign buf_a_raddr_o = issue_addr;
    assign buf_b_raddr_o = issue_addr;

    // rows come back one cycle after their address
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_vld  <= 1'b0;
            rd_last <= 1'b0;
            done_o  <= 1'b0;
        end else begin
            rd_vld  <= issue_act;
            rd_last <= issue_act && (issue_addr == '1);
            done_o  <= rd_last;
        end
    end

    // C[i][j] += A[i][k] * B[k][j], with column k of A and row k of B
    always_ff @(posedge clk) begin
        for (int i = 0; i < `MM_SA; i++) begin
            for (int j = 0; j < `MM_SA; j++) begin
                if (start_i) begin
                    accum_o[i][j] <= '0;
                end else if (rd_vld) begin
                    accum_o[i][j] <= accum_o[i][j]
                        + $signed(buf_a_rdata_i.elem[i]) * $signed(buf_b_rdata_i.elem[j]);
                end
            end
        end
    end

endmodule

/* dma_engine.sv */
/*
 * Reads A (id 0) and B (id 1) as two outstanding 16-beat bursts, packs four
 * beats per buffer row, runs the engine and writes C back as 16 beats.
 * Burst length, size, type and strobes are fixed and left to the memory side.
 * The write response code is ignored.
 */
`timescale 1ns/10ps
`include "mm_accel_settings.svh"

module dma_engine (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [31:0]                 mat_a_addr_i,
    input  logic [31:0]                 mat_b_addr_i,
    input  logic [31:0]                 mat_c_addr_i,
    input  logic                        start_i,
    output logic                        done_o,
    output logic                        arvalid_o,
    input  logic                        arready_i,
    output logic [31:0]                 araddr_o,
    output logic                        arid_o,
    input  logic                        rvalid_i,
    output logic                        rready_o,
    input  logic                        rid_i,
    input  logic [`MM_DW-1:0]           rdata_i,
    input  logic                        rlast_i,
    output logic                        awvalid_o,
    input  logic                        awready_i,
    output logic [31:0]                 awaddr_o,
    output logic                        wvalid_o,
    input  logic                        wready_i,
    output logic [`MM_DW-1:0]           wdata_o,
    output logic                        wlast_o,
    input  logic                        bvalid_i,
    output logic                        bready_o,
    output logic                        buf_a_wren_o,
    output logic [`MM_BUF_AW-1:0]       buf_a_waddr_o,
    output logic [`MM_BUF_DW/8-1:0]     buf_a_wbyteen_o,
    output mm_accel_pkg::buf_row_u      buf_a_wdata_o,
    output logic                        buf_b_wren_o,
    output logic [`MM_BUF_AW-1:0]       buf_b_waddr_o,
    output logic [`MM_BUF_DW/8-1:0]     buf_b_wbyteen_o,
    output mm_accel_pkg::buf_row_u      buf_b_wdata_o,
    output logic                        mm_start_o,
    input  logic                        mm_done_i,
    input  mm_accel_pkg::accum_t        accum_i [`MM_SA][`MM_SA]
);

    localparam logic [2:0] st_idle    = 3'd0;
    localparam logic [2:0] st_ar_a    = 3'd1;
    localparam logic [2:0] st_ar_b    = 3'd2;
    localparam logic [2:0] st_load    = 3'd3;
    localparam logic [2:0] st_wait_mm = 3'd4;
    localparam logic [2:0] st_aw_c    = 3'd5;
    localparam logic [2:0] st_w_c     = 3'd6;
    localparam logic [2:0] st_b_resp  = 3'd7;

    logic [2:0]                 state;
    logic                       job_start;
    logic                       r_hs;
    logic                       w_hs;
    logic                       all_done;
    logic [31:0]                a_addr_q;
    logic [31:0]                b_addr_q;
    logic [31:0]                c_addr_q;
    logic [3:0]                 elem_idx;
    // per read id: 0 is A, 1 is B
    logic [3:0]                 beat_cnt [2];
    logic                       id_done  [2];
    logic                       row_wren [2];
    logic [`MM_BUF_AW-1:0]      row_addr [2];
    mm_accel_pkg::buf_row_u     row_asm  [2];

    assign job_start = (state == st_idle) && start_i;
    assign r_hs      = rvalid_i && rready_o;
    assign w_hs      = wvalid_o && wready_i;
    assign all_done  = id_done[0] && id_done[1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= st_idle;
            mm_start_o <= 1'b0;
            done_o     <= 1'b0;
        end else begin
            mm_start_o <= 1'b0;
            done_o     <= 1'b0;
            case (state)
                st_idle:    if (start_i) state <= st_ar_a;
                st_ar_a:    if (arready_i) state <= st_ar_b;
                st_ar_b:    if (arready_i) state <= st_load;
                st_load: begin
                    // first cycle with both bursts in is the last row write
                    if (all_done) begin
                        mm_start_o <= 1'b1;
                        state      <= st_wait_mm;
                    end
                end
                st_wait_mm: if (mm_done_i) state <= st_aw_c;
                st_aw_c:    if (awready_i) state <= st_w_c;
                st_w_c:     if (w_hs && wlast_o) state <= st_b_resp;
                st_b_resp: begin
                    if (bvalid_i) begin
                        done_o <= 1'b1;
                        state  <= st_idle;
                    end
                end
                default:    state <= st_idle;
            endcase
        end
    end

    // addresses held for the whole job
    always_ff @(posedge clk) begin
        if (job_start) begin
            a_addr_q <= mat_a_addr_i;
            b_addr_q <= mat_b_addr_i;
            c_addr_q <= mat_c_addr_i;
        end
    end

    // beat counting, row write strobe on every fourth beat
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int id = 0; id < 2; id++) begin
                beat_cnt[id] <= '0;
                id_done[id]  <= 1'b0;
                row_wren[id] <= 1'b0;
            end
        end else begin
            for (int id = 0; id < 2; id++) begin
                row_wren[id] <= 1'b0;
                if (job_start) begin
                    beat_cnt[id] <= '0;
                    id_done[id]  <= 1'b0;
                end else if (r_hs && (rid_i == id[0])) begin
                    beat_cnt[id] <= beat_cnt[id] + 1'b1;
                    if (beat_cnt[id][1:0] == 2'd3)
                        row_wren[id] <= 1'b1;
                    if (rlast_i)
                        id_done[id] <= 1'b1;
                end
            end
        end
    end

    // row assembly, beat n of a row lands in element n
    always_ff @(posedge clk) begin
        for (int id = 0; id < 2; id++) begin
            if (r_hs && (rid_i == id[0])) begin
                row_asm[id].raw[beat_cnt[id][1:0]*`MM_DW +: `MM_DW] <= rdata_i;
                row_addr[id] <= beat_cnt[id][3:2];
            end
        end
    end

    // write-back walks C row by row
    always_ff @(posedge clk) begin
        if (!rst_n)
            elem_idx <= '0;
        else if (job_start)
            elem_idx <= '0;
        else if (w_hs)
            elem_idx <= elem_idx + 1'b1;
    end

    assign arvalid_o = (state == st_ar_a) || (state == st_ar_b);
    assign arid_o    = (state == st_ar_b);
    assign araddr_o  = arid_o ? b_addr_q : a_addr_q;
    assign rready_o  = (state == st_load) && !all_done;

    assign awvalid_o = (state == st_aw_c);
    assign awaddr_o  = c_addr_q;
    assign wvalid_o  = (state == st_w_c);
    assign wlast_o   = wvalid_o && (elem_idx == `MM_SA*`MM_SA-1);
    // low half of the accumulator only
    assign wdata_o   = accum_i[elem_idx[3:2]][elem_idx[1:0]][`MM_DW-1:0];
    assign bready_o  = (state == st_b_resp);

    assign buf_a_wren_o    = row_wren[0];
    assign buf_a_waddr_o   = row_addr[0];
    assign buf_a_wbyteen_o = {(`MM_BUF_DW/8){row_wren[0]}};
    assign buf_a_wdata_o   = row_asm[0];
    assign buf_b_wren_o    = row_wren[1];
    assign buf_b_waddr_o   = row_addr[1];
    assign buf_b_wbyteen_o = {(`MM_BUF_DW/8){row_wren[1]}};
    assign buf_b_wdata_o   = row_asm[1];

endmodule

/* mm_accel_top.sv */
/*
 * Matrix accelerator top: DMA, two tile buffers and the 4x4 engine.
 * A must be stored column-major and B row-major. Configuration inputs must
 * be stable when start_i is given.
 */
`timescale 1ns/10ps
`include "mm_accel_settings.svh"

module mm_accel_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [31:0]         mat_a_addr_i,
    input  logic [31:0]         mat_b_addr_i,
    input  logic [31:0]         mat_c_addr_i,
    input  logic                start_i,
    output logic                done_o,
    output logic                arvalid_o,
    input  logic                arready_i,
    output logic [31:0]         araddr_o,
    output logic                arid_o,
    input  logic                rvalid_i,
    output logic                rready_o,
    input  logic                rid_i,
    input  logic [`MM_DW-1:0]   rdata_i,
    input  logic                rlast_i,
    output logic                awvalid_o,
    input  logic                awready_i,
    output logic [31:0]         awaddr_o,
    output logic                wvalid_o,
    input  logic                wready_i,
    output logic [`MM_DW-1:0]   wdata_o,
    output logic                wlast_o,
    input  logic                bvalid_i,
    output logic                bready_o
);

    logic                       buf_a_wren;
    logic [`MM_BUF_AW-1:0]      buf_a_waddr;
    logic [`MM_BUF_DW/8-1:0]    buf_a_wbyteen;
    mm_accel_pkg::buf_row_u     buf_a_wdata;
    logic [`MM_BUF_AW-1:0]      buf_a_raddr;
    mm_accel_pkg::buf_row_u     buf_a_rdata;
    logic                       buf_b_wren;
    logic [`MM_BUF_AW-1:0]      buf_b_waddr;
    logic [`MM_BUF_DW/8-1:0]    buf_b_wbyteen;
    mm_accel_pkg::buf_row_u     buf_b_wdata;
    logic [`MM_BUF_AW-1:0]      buf_b_raddr;
    mm_accel_pkg::buf_row_u     buf_b_rdata;
    logic                       mm_start;
    logic                       mm_done;
    mm_accel_pkg::accum_t       accum [`MM_SA][`MM_SA];

    dma_engine u_dma (
        .clk             (clk),
        .rst_n           (rst_n),
        .mat_a_addr_i    (mat_a_addr_i),
        .mat_b_addr_i    (mat_b_addr_i),
        .mat_c_addr_i    (mat_c_addr_i),
        .start_i         (start_i),
        .done_o          (done_o),
        .arvalid_o       (arvalid_o),
        .arready_i       (arready_i),
        .araddr_o        (araddr_o),
        .arid_o          (arid_o),
        .rvalid_i        (rvalid_i),
        .rready_o        (rready_o),
        .rid_i           (rid_i),
        .rdata_i         (rdata_i),
        .rlast_i         (rlast_i),
        .awvalid_o       (awvalid_o),
        .awready_i       (awready_i),
        .awaddr_o        (awaddr_o),
        .wvalid_o        (wvalid_o),
        .wready_i        (wready_i),
        .wdata_o         (wdata_o),
        .wlast_o         (wlast_o),
        .bvalid_i        (bvalid_i),
        .bready_o        (bready_o),
        .buf_a_wren_o    (buf_a_wren),
        .buf_a_waddr_o   (buf_a_waddr),
        .buf_a_wbyteen_o (buf_a_wbyteen),
        .buf_a_wdata_o   (buf_a_wdata),
        .buf_b_wren_o    (buf_b_wren),
        .buf_b_waddr_o   (buf_b_waddr),
        .buf_b_wbyteen_o (buf_b_wbyteen),
        .buf_b_wdata_o   (buf_b_wdata),
        .mm_start_o      (mm_start),
        .mm_done_i       (mm_done),
        .accum_i         (accum)
    );

    // columns of A
    tile_buffer u_buf_a (
        .clk       (clk),
        .rst_n     (rst_n),
        .wren_i    (buf_a_wren),
        .waddr_i   (buf_a_waddr),
        .wbyteen_i (buf_a_wbyteen),
        .wdata_i   (buf_a_wdata),
        .raddr_i   (buf_a_raddr),
        .rdata_o   (buf_a_rdata)
    );

    // rows of B
    tile_buffer u_buf_b (
        .clk       (clk),
        .rst_n     (rst_n),
        .wren_i    (buf_b_wren),
        .waddr_i   (buf_b_waddr),
        .wbyteen_i (buf_b_wbyteen),
        .wdata_i   (buf_b_wdata),
        .raddr_i   (buf_b_raddr),
        .rdata_o   (buf_b_rdata)
    );

    mm_engine u_mm (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_i       (mm_start),
        .done_o        (mm_done),
        .buf_a_raddr_o (buf_a_raddr),
        .buf_a_rdata_i (buf_a_rdata),
        .buf_b_raddr_o (buf_b_raddr),
        .buf_b_rdata_i (buf_b_rdata),
        .accum_o       (accum)
    );

endmodule

/* tb_clk_gen.sv */
/*
 * Testbench clock and reset. 10 ns clock period.
 * Reset is held low for the first 10 rising edges.
 */
`timescale 1ns/10ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (10) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

/* mm_accel_tb.sv */
/*
 * Testbench for the matrix accelerator. Two jobs run against a word memory
 * model with random ready drops, gaps in read data and interleaved read ids.
 * The memory model assumes 16-beat, 4-byte incrementing bursts.
 */
`timescale 1ns/10ps

module mm_accel_tb;

    localparam int timeout_cycles = 4000;

    logic clk;
    logic rst_n;
    logic [31:0] mat_a_addr_i = '0;
    logic [31:0] mat_b_addr_i = '0;
    logic [31:0] mat_c_addr_i = '0;
    logic start_i = 1'b0;
    logic arready_i = 1'b0;
    logic rvalid_i = 1'b0;
    logic rid_i = 1'b0;
    logic [31:0] rdata_i = '0;
    logic rlast_i = 1'b0;
    logic awready_i = 1'b0;
    logic wready_i = 1'b0;
    logic bvalid_i = 1'b0;
    logic done_o, arvalid_o, arid_o, rready_o, awvalid_o, wvalid_o, wlast_o, bready_o;
    logic [31:0] araddr_o, awaddr_o, wdata_o;

    int mem [128];
    logic [15:0] lfsr = 16'd262;
    logic [6:0] rd_base [2];
    logic [4:0] rd_beat [2];
    logic [4:0] rd_left [2];
    logic [31:0] exp_c [16];
    logic [31:0] cur_a, cur_b, cur_c;
    logic [2:0] ar_cnt = '0;
    logic [1:0] aw_cnt = '0;
    logic [4:0] w_idx = '0;
    int done_cnt = 0;
    int cycle_cnt = 0;
    logic rst_d = 1'b0;
    logic reset_seen = 1'b0;
    logic prev_ar_stall = 1'b0;
    logic prev_w_stall = 1'b0;
    logic prev_b_hs = 1'b0;
    logic prev_done = 1'b0;
    logic [31:0] prev_araddr, prev_wdata;
    logic prev_arid;

    tb_clk_gen u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

    mm_accel_top u_mm_accel_top (
        .clk(clk), .rst_n(rst_n),
        .mat_a_addr_i(mat_a_addr_i), .mat_b_addr_i(mat_b_addr_i),
        .mat_c_addr_i(mat_c_addr_i), .start_i(start_i), .done_o(done_o),
        .arvalid_o(arvalid_o), .arready_i(arready_i), .araddr_o(araddr_o),
        .arid_o(arid_o), .rvalid_i(rvalid_i), .rready_o(rready_o), .rid_i(rid_i),
        .rdata_i(rdata_i), .rlast_i(rlast_i), .awvalid_o(awvalid_o),
        .awready_i(awready_i), .awaddr_o(awaddr_o), .wvalid_o(wvalid_o),
        .wready_i(wready_i), .wdata_o(wdata_o), .wlast_o(wlast_o),
        .bvalid_i(bvalid_i), .bready_o(bready_o)
    );

    // steps the 16-bit Fibonacci LFSR (taps 16 14 13 11) and returns the new bit
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    // C[n/4][n%4] with A column-major at word a_w and B row-major at word b_w
    function automatic logic [31:0] ref_elem(input int a_w, input int b_w, input int n);
        longint acc;
        acc = 0;
        for (int k = 0; k < 4; k++)
            acc += longint'(mem[a_w + k*4 + n/4]) * longint'(mem[b_w + k*4 + n%4]);
        return acc[31:0];
    endfunction

    task automatic report_mismatch(input string sig, input logic [63:0] exp_v,
                                   input logic [63:0] act_v);
        $display("CHECK FAILED at %0t ns: %s expected 0x%0h got 0x%0h", $time, sig, exp_v, act_v);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    // memory model with random ready drops, gapped and interleaved reads and the B response
    always @(posedge clk) begin : mem_model
        logic gap;
        logic sel;
        logic id;
        if (!rst_n) begin
            arready_i <= 1'b0;
            awready_i <= 1'b0;
            wready_i <= 1'b0;
            rvalid_i <= 1'b0;
            rlast_i <= 1'b0;
            bvalid_i <= 1'b0;
            rd_left[0] <= '0;
            rd_left[1] <= '0;
        end else begin
            // the B request always waits at least one cycle for arready
            arready_i <= (lfsr_bit() | lfsr_bit()) && !(arvalid_o && arready_i && !arid_o);
            awready_i <= lfsr_bit() | lfsr_bit();
            wready_i <= lfsr_bit() | lfsr_bit();
            if (arvalid_o && arready_i) begin
                rd_base[arid_o] <= araddr_o[8:2];
                rd_beat[arid_o] <= '0;
                rd_left[arid_o] <= 5'd16;
            end
            if (!rvalid_i || rready_o) begin
                gap = lfsr_bit() & lfsr_bit();
                sel = lfsr_bit();
                id = (rd_left[0] != 0 && rd_left[1] != 0) ? sel : (rd_left[1] != 0);
                if (gap || rd_left[id] == 0) begin
                    rvalid_i <= 1'b0;
                end else begin
                    rvalid_i <= 1'b1;
                    rid_i <= id;
                    rdata_i <= mem[rd_base[id] + rd_beat[id]];
                    rlast_i <= (rd_left[id] == 5'd1);
                    rd_beat[id] <= rd_beat[id] + 1'b1;
                    rd_left[id] <= rd_left[id] - 1'b1;
                end
            end
            if (wvalid_o && wready_i && wlast_o)
                bvalid_i <= 1'b1;
            else if (bvalid_i && bready_o)
                bvalid_i <= 1'b0;
        end
    end

    // per-job handshake counts and one-cycle history for the checks
    always @(posedge clk) begin
        rst_d <= rst_n;
        reset_seen <= 1'b1;
        prev_ar_stall <= arvalid_o && !arready_i;
        prev_araddr <= araddr_o;
        prev_arid <= arid_o;
        prev_w_stall <= wvalid_o && !wready_i;
        prev_wdata <= wdata_o;
        prev_b_hs <= bvalid_i && bready_o;
        prev_done <= done_o;
        if (!rst_n || done_o) begin
            ar_cnt <= '0;
            aw_cnt <= '0;
            w_idx <= '0;
        end else begin
            if (arvalid_o && arready_i)
                ar_cnt <= ar_cnt + 1'b1;
            if (awvalid_o && awready_i)
                aw_cnt <= aw_cnt + 1'b1;
            if (wvalid_o && wready_i)
                w_idx <= w_idx + 1'b1;
        end
        if (rst_n && done_o)
            done_cnt <= done_cnt + 1;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == timeout_cycles) begin
            $display("Timeout: the jobs did not finish within %0d cycles", timeout_cycles);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    end

    a_reset_quiet: assert property (@(posedge clk) reset_seen && (!rst_n || !rst_d)
        |-> !(arvalid_o | rready_o | awvalid_o | wvalid_o | bready_o | done_o))
        else report_mismatch("arvalid/rready/awvalid/wvalid/bready/done", 0,
            $sampled({arvalid_o, rready_o, awvalid_o, wvalid_o, bready_o, done_o}));
    a_ar_count: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid_o && arready_i |-> ar_cnt < 2)
        else report_mismatch("read request count", 2, $sampled(ar_cnt) + 1);
    a_ar_id: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid_o && arready_i |-> arid_o == ar_cnt[0])
        else report_mismatch("arid_o", $sampled(ar_cnt[0]), $sampled(arid_o));
    a_ar_addr: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid_o && arready_i |-> araddr_o == (ar_cnt[0] ? cur_b : cur_a))
        else report_mismatch("araddr_o", $sampled(ar_cnt[0] ? cur_b : cur_a),
            $sampled(araddr_o));
    a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        prev_ar_stall |-> arvalid_o && araddr_o == prev_araddr && arid_o == prev_arid)
        else report_mismatch("arvalid_o/araddr_o/arid_o held",
            $sampled({1'b1, prev_arid, prev_araddr}),
            $sampled({arvalid_o, arid_o, araddr_o}));
    a_aw_once: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid_o && awready_i |-> aw_cnt == 0 && awaddr_o == cur_c)
        else report_mismatch("awaddr_o", $sampled(cur_c), $sampled(awaddr_o));
    a_w_data: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid_o && wready_i |-> w_idx < 16 && wdata_o == exp_c[w_idx[3:0]])
        else report_mismatch("wdata_o", $sampled(exp_c[w_idx[3:0]]), $sampled(wdata_o));
    a_w_last: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid_o && wready_i |-> wlast_o == (w_idx == 15))
        else report_mismatch("wlast_o", $sampled(w_idx == 15), $sampled(wlast_o));
    a_w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        prev_w_stall |-> wvalid_o && wdata_o == prev_wdata)
        else report_mismatch("wvalid_o/wdata_o held", $sampled({1'b1, prev_wdata}),
            $sampled({wvalid_o, wdata_o}));
    a_done_after_b: assert property (@(posedge clk) disable iff (!rst_n)
        done_o |-> prev_b_hs && ar_cnt == 2 && aw_cnt == 1 && w_idx == 16)
        else report_mismatch("done_o handshakes {b, ar, aw, w}", {1'b1, 3'd2, 2'd1, 5'd16},
            $sampled({prev_b_hs, ar_cnt, aw_cnt, w_idx}));
    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done_o |-> !prev_done)
        else report_mismatch("done_o pulse length", 1, 2);

    task automatic run_job(input logic [31:0] a, input logic [31:0] b, input logic [31:0] c);
        cur_a = a;
        cur_b = b;
        cur_c = c;
        for (int n = 0; n < 16; n++)
            exp_c[n] = ref_elem(a[8:2], b[8:2], n);
        @(posedge clk);
        mat_a_addr_i <= a;
        mat_b_addr_i <= b;
        mat_c_addr_i <= c;
        start_i <= 1'b1;
        @(posedge clk);
        start_i <= 1'b0;
        // a start while busy must be ignored
        repeat (5) @(posedge clk);
        start_i <= 1'b1;
        @(posedge clk);
        start_i <= 1'b0;
        wait (done_o);
        @(posedge clk);
    endtask

    initial begin
        // small positive words for job 1 and negative words for job 2
        for (int w = 0; w < 128; w++)
            mem[w] = (w < 64) ? (w * 3 + 1) : -(w * w * 977 + 12345);
        wait (rst_n);
        repeat (3) @(posedge clk);
        run_job(32'h000, 32'h040, 32'h080);
        repeat (4) @(posedge clk);
        run_job(32'h100, 32'h140, 32'h180);
        repeat (5) @(posedge clk);
        if (done_cnt == 2) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("Expected two done pulses but saw %0d", done_cnt);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    end

endmodule

/* mm_accel.f */
+incdir+.
mm_accel_pkg.sv
tile_buffer.sv
mm_engine.sv
dma_engine.sv
mm_accel_top.sv
tb_clk_gen.sv
mm_accel_tb.sv

/* Makefile */
# Verilator build and run of the matrix accelerator testbench

VERILATOR ?= verilator
TOP       ?= mm_accel_tb
FILELIST  ?= mm_accel.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "test passed" || (echo "test failed"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
